//--- hdl/chrono_pkg.sv
// Shared types and memory map; the decoder assumes a 20-bit internal word address space
`default_nettype none

package chrono_pkg;

  // Host bus and banking
  localparam int MPU_ADDR_WIDTH    = 16;
  localparam int MPU_DATA_WIDTH    = 16;
  localparam int PAGE_OFFSET_WIDTH = 12;
  localparam int BANK_WIDTH        = 8;
  localparam int INT_ADDR_WIDTH    = BANK_WIDTH + PAGE_OFFSET_WIDTH;

  typedef logic [MPU_DATA_WIDTH-1:0] word_t;

  typedef struct packed {
    logic                      rd;
    logic                      wr;
    logic [1:0]                be;
    logic [MPU_ADDR_WIDTH-1:0] addr;
    word_t                     wdata;
  } mpu_req_t;

  typedef struct packed {
    logic [BANK_WIDTH-1:0]        page;
    logic [PAGE_OFFSET_WIDTH-1:0] offset;
  } int_addr_t;

  typedef struct packed {
    logic [7:0] blue;
    logic [7:0] green;
    logic [7:0] red;
  } pal_entry_t;

  // Field order puts h_sync in bit 0 of OUTPUT_STATUS
  typedef struct packed {
    logic v_blank;
    logic h_blank;
    logic v_sync;
    logic h_sync;
  } disp_status_t;

  // Region bases and lengths, in words
  localparam logic [INT_ADDR_WIDTH-1:0] MAIN_REG_BASE = 20'h00000;
  localparam logic [INT_ADDR_WIDTH-1:0] MAIN_REG_SIZE = 20'h00010;
  localparam logic [INT_ADDR_WIDTH-1:0] PAL_BASE      = 20'h00800;
  localparam logic [INT_ADDR_WIDTH-1:0] PAL_SIZE      = 20'h00200;
  localparam logic [INT_ADDR_WIDTH-1:0] VRAM_BASE     = 20'h10000;
  localparam logic [INT_ADDR_WIDTH-1:0] VRAM_SIZE     = 20'h10000;

  localparam int VRAM_ADDR_WIDTH = 16;
  localparam int PAL_ADDR_WIDTH  = 9;
  localparam int PAL_ENTRIES     = 256;
  localparam int REG_ADDR_WIDTH  = 4;

  localparam word_t UNMAPPED_VALUE = 16'hdead;
  localparam word_t ID_VALUE       = 16'h0c3b;

  // Main register indices
  localparam logic [REG_ADDR_WIDTH-1:0] REG_ID            = 4'd0;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_SYS_CTRL      = 4'd1;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_MEM_BANK      = 4'd2;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_OUTPUT_STATUS = 4'd3;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_SCAN_X        = 4'd4;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_SCAN_Y        = 4'd5;

  localparam int SYS_CTRL_VRAM_ACCESS = 0;
  localparam int COUNT_WIDTH          = 10;

endpackage

`default_nettype wire

//--- hdl/mpu_decoder.sv
// Page 0 is never banked; rd and wr must not be high together, responses are never stalled
`timescale 1ns/1ps
`default_nettype none

module mpu_decoder import chrono_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire mpu_req_t         mpu_req,
  input  wire [BANK_WIDTH-1:0]  bank,
  output logic                  reg_sel,
  output logic                  pal_sel,
  output logic                  vram_sel,
  output int_addr_t             word_addr,
  input  wire word_t            reg_rdata,
  input  wire word_t            pal_rdata,
  input  wire word_t            vram_rdata,
  output word_t                 rdata,
  output logic                  rdata_valid
);

  localparam int PAGE_INDEX_WIDTH = MPU_ADDR_WIDTH - PAGE_OFFSET_WIDTH;

  function automatic logic in_region(input logic [INT_ADDR_WIDTH-1:0] a,
                                     input logic [INT_ADDR_WIDTH-1:0] base,
                                     input logic [INT_ADDR_WIDTH-1:0] size);
    return (a >= base) && (a < base + size);
  endfunction

  logic [PAGE_INDEX_WIDTH-1:0] page_index;
  int_addr_t                   int_addr;
  logic                        req_active;
  logic                        reg_hit;
  logic                        pal_hit;
  logic                        vram_hit;
  logic [INT_ADDR_WIDTH-1:0]   region_base;
  logic [2:0]                  hit_q;
  logic                        rd_q;

  // Bank mapping
  assign page_index      = mpu_req.addr[MPU_ADDR_WIDTH-1:PAGE_OFFSET_WIDTH];
  assign int_addr.page   = (page_index == '0) ? '0 : bank;
  assign int_addr.offset = mpu_req.addr[PAGE_OFFSET_WIDTH-1:0];

  assign req_active = mpu_req.rd | mpu_req.wr;
  assign reg_hit    = in_region(int_addr, MAIN_REG_BASE, MAIN_REG_SIZE);
  assign pal_hit    = in_region(int_addr, PAL_BASE, PAL_SIZE);
  assign vram_hit   = in_region(int_addr, VRAM_BASE, VRAM_SIZE);

  assign reg_sel  = req_active & reg_hit;
  assign pal_sel  = req_active & pal_hit;
  assign vram_sel = req_active & vram_hit;

  // Region-relative word address
  always_comb begin
    region_base = MAIN_REG_BASE;
    if (pal_hit) begin
      region_base = PAL_BASE;
    end else if (vram_hit) begin
      region_base = VRAM_BASE;
    end
    word_addr = int_addr_t'(int_addr - region_base);
  end

  // Remember which block answers next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_q <= '0;
      rd_q  <= 1'b0;
    end else begin
      hit_q <= {vram_sel, pal_sel, reg_sel};
      rd_q  <= mpu_req.rd;
    end
  end

  always_comb begin
    case (hit_q)
      3'b001:  rdata = reg_rdata;
      3'b010:  rdata = pal_rdata;
      3'b100:  rdata = vram_rdata;
      default: rdata = UNMAPPED_VALUE;
    endcase
  end

  assign rdata_valid = rd_q;

  a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mpu_req.rd && mpu_req.wr));

  a_one_region: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({reg_sel, pal_sel, vram_sel}));

endmodule

`default_nettype wire

//--- hdl/main_registers.sv
// Only the low byte of MEM_BANK is stored; read-only indices silently drop writes
`timescale 1ns/1ps
`default_nettype none

module main_registers import chrono_pkg::*; (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      sel,
  input  wire mpu_req_t            mpu_req,
  input  wire [REG_ADDR_WIDTH-1:0] word_addr,
  input  wire disp_status_t        status,
  input  wire [COUNT_WIDTH-1:0]    scan_x,
  input  wire [COUNT_WIDTH-1:0]    scan_y,
  output word_t                    rdata,
  output logic [BANK_WIDTH-1:0]    bank,
  output logic                     vram_access
);

  word_t                 sys_ctrl;
  logic [BANK_WIDTH-1:0] mem_bank;
  logic                  wr_en;
  logic                  rd_en;
  word_t                 rd_word;

  assign wr_en = sel & mpu_req.wr;
  assign rd_en = sel & mpu_req.rd;

  // Writable registers, per byte lane
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sys_ctrl <= '0;
      mem_bank <= '0;
    end else if (wr_en) begin
      case (word_addr)
        REG_SYS_CTRL: begin
          if (mpu_req.be[0]) sys_ctrl[7:0] <= mpu_req.wdata[7:0];
          if (mpu_req.be[1]) sys_ctrl[15:8] <= mpu_req.wdata[15:8];
        end
        REG_MEM_BANK: begin
          if (mpu_req.be[0]) mem_bank <= mpu_req.wdata[7:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (word_addr)
      REG_ID:            rd_word = ID_VALUE;
      REG_SYS_CTRL:      rd_word = sys_ctrl;
      REG_MEM_BANK:      rd_word = word_t'(mem_bank);
      REG_OUTPUT_STATUS: rd_word = word_t'(status);
      REG_SCAN_X:        rd_word = word_t'(scan_x);
      REG_SCAN_Y:        rd_word = word_t'(scan_y);
      default:           rd_word = '0;
    endcase
  end

  // Read data lands one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= rd_word;
    end
  end

  assign bank        = mem_bank;
  assign vram_access = sys_ctrl[SYS_CTRL_VRAM_ACCESS];

endmodule

`default_nettype wire

//--- hdl/palette_ram.sv
// Host port only; even words carry red/green, odd words blue with a zero high byte
`timescale 1ns/1ps
`default_nettype none

module palette_ram import chrono_pkg::*; (
  input  wire                      clk,
  input  wire                      sel,
  input  wire mpu_req_t            mpu_req,
  input  wire [PAL_ADDR_WIDTH-1:0] word_addr,
  output word_t                    rdata
);

  pal_entry_t                    mem [PAL_ENTRIES];
  logic [PAL_ADDR_WIDTH-2:0]     index;
  logic                          odd_word;

  // Two host words per entry
  assign index    = word_addr[PAL_ADDR_WIDTH-1:1];
  assign odd_word = word_addr[0];

  always_ff @(posedge clk) begin
    if (sel && mpu_req.wr) begin
      if (!odd_word) begin
        if (mpu_req.be[0]) mem[index].red <= mpu_req.wdata[7:0];
        if (mpu_req.be[1]) mem[index].green <= mpu_req.wdata[15:8];
      end else if (mpu_req.be[0]) begin
        mem[index].blue <= mpu_req.wdata[7:0];
      end
    end
  end

  // Synchronous read
  always_ff @(posedge clk) begin
    if (sel && mpu_req.rd) begin
      if (odd_word) begin
        rdata <= {8'h00, mem[index].blue};
      end else begin
        rdata <= {mem[index].green, mem[index].red};
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/display_timing.sv
// Syncs are active low; all totals must fit in COUNT_WIDTH bits
`timescale 1ns/1ps
`default_nettype none

module display_timing import chrono_pkg::*; #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  wire                    clk,
  input  wire                    rst_n,
  output disp_status_t           status,
  output logic [COUNT_WIDTH-1:0] scan_x,
  output logic [COUNT_WIDTH-1:0] scan_y,
  output logic                   h_sync,
  output logic                   v_sync
);

  localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

  logic [COUNT_WIDTH-1:0] h_cnt;
  logic [COUNT_WIDTH-1:0] v_cnt;
  logic                   h_wrap;
  logic                   v_wrap;
  logic                   h_blank;
  logic                   v_blank;

  assign h_wrap = (h_cnt == COUNT_WIDTH'(H_TOTAL - 1));
  assign v_wrap = (v_cnt == COUNT_WIDTH'(V_TOTAL - 1));

  // Pixel and line counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      h_cnt <= h_wrap ? '0 : h_cnt + 1'b1;
      if (h_wrap) begin
        v_cnt <= v_wrap ? '0 : v_cnt + 1'b1;
      end
    end
  end

  // Visible area first, then front porch, sync, back porch
  assign h_blank = (h_cnt >= COUNT_WIDTH'(H_VISIBLE));
  assign v_blank = (v_cnt >= COUNT_WIDTH'(V_VISIBLE));
  assign h_sync  = !((h_cnt >= COUNT_WIDTH'(H_SYNC_START)) &&
                     (h_cnt < COUNT_WIDTH'(H_SYNC_START + H_SYNC)));
  assign v_sync  = !((v_cnt >= COUNT_WIDTH'(V_SYNC_START)) &&
                     (v_cnt < COUNT_WIDTH'(V_SYNC_START + V_SYNC)));

  assign scan_x = h_blank ? '0 : h_cnt;
  assign scan_y = v_blank ? '0 : v_cnt;

  assign status = '{v_blank: v_blank, h_blank: h_blank, v_sync: v_sync, h_sync: h_sync};

endmodule

`default_nettype wire

//--- hdl/vram_port.sv
// External VRAM must return read data combinationally in the cycle after the request
`timescale 1ns/1ps
`default_nettype none

module vram_port import chrono_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       sel,
  input  wire mpu_req_t             mpu_req,
  input  wire [VRAM_ADDR_WIDTH-1:0] word_addr,
  input  wire                       vram_access,
  input  wire word_t                vram_rdata,
  output logic                      vram_en,
  output logic                      vram_rd,
  output logic                      vram_wr,
  output logic [1:0]                vram_be,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  output word_t                     vram_wdata,
  output word_t                     rdata
);

  logic       host_go;
  logic [1:0] be_q;
  word_t      wdata_q;

  assign host_go = sel & vram_access;
  assign vram_en = vram_access;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vram_rd <= 1'b0;
      vram_wr <= 1'b0;
    end else begin
      vram_rd <= host_go & mpu_req.rd;
      vram_wr <= host_go & mpu_req.wr;
    end
  end

  // Address and payload follow the strobes by the same cycle
  always_ff @(posedge clk) begin
    if (host_go) begin
      vram_addr <= word_addr;
      be_q      <= mpu_req.be;
      wdata_q   <= mpu_req.wdata;
    end
  end

  assign vram_be    = vram_access ? be_q : 2'b00;
  assign vram_wdata = vram_access ? wdata_q : '0;

  // No pin read means access was off
  assign rdata = vram_rd ? vram_rdata : UNMAPPED_VALUE;

  a_wr_needs_access: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(vram_wr) |-> vram_en);

endmodule

`default_nettype wire

//--- hdl/chrono_cube.sv
// Host side only, no renderer; vga syncs are active low and VRAM is idle unless host access is on
`timescale 1ns/1ps
`default_nettype none

module chrono_cube import chrono_pkg::*; #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire mpu_req_t              mpu_req,
  output word_t                      rdata,
  output logic                       rdata_valid,
  output logic                       vram_en,
  output logic                       vram_rd,
  output logic                       vram_wr,
  output logic [1:0]                 vram_be,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  output word_t                      vram_wdata,
  input  wire word_t                 vram_rdata,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  logic                   reg_sel;
  logic                   pal_sel;
  logic                   vram_sel;
  int_addr_t              word_addr;
  word_t                  reg_rdata;
  word_t                  pal_rdata;
  word_t                  vram_rsp;
  logic [BANK_WIDTH-1:0]  bank;
  logic                   vram_access;
  disp_status_t           status;
  logic [COUNT_WIDTH-1:0] scan_x;
  logic [COUNT_WIDTH-1:0] scan_y;

  mpu_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .mpu_req     (mpu_req),
    .bank        (bank),
    .reg_sel     (reg_sel),
    .pal_sel     (pal_sel),
    .vram_sel    (vram_sel),
    .word_addr   (word_addr),
    .reg_rdata   (reg_rdata),
    .pal_rdata   (pal_rdata),
    .vram_rdata  (vram_rsp),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  main_registers u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel         (reg_sel),
    .mpu_req     (mpu_req),
    .word_addr   (word_addr[REG_ADDR_WIDTH-1:0]),
    .status      (status),
    .scan_x      (scan_x),
    .scan_y      (scan_y),
    .rdata       (reg_rdata),
    .bank        (bank),
    .vram_access (vram_access)
  );

  palette_ram u_palette (
    .clk       (clk),
    .sel       (pal_sel),
    .mpu_req   (mpu_req),
    .word_addr (word_addr[PAL_ADDR_WIDTH-1:0]),
    .rdata     (pal_rdata)
  );

  vram_port u_vram (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel         (vram_sel),
    .mpu_req     (mpu_req),
    .word_addr   (word_addr[VRAM_ADDR_WIDTH-1:0]),
    .vram_access (vram_access),
    .vram_rdata  (vram_rdata),
    .vram_en     (vram_en),
    .vram_rd     (vram_rd),
    .vram_wr     (vram_wr),
    .vram_be     (vram_be),
    .vram_addr   (vram_addr),
    .vram_wdata  (vram_wdata),
    .rdata       (vram_rsp)
  );

  display_timing #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) u_timing (
    .clk    (clk),
    .rst_n  (rst_n),
    .status (status),
    .scan_x (scan_x),
    .scan_y (scan_y),
    .h_sync (vga_hsync),
    .v_sync (vga_vsync)
  );

endmodule

`default_nettype wire

//--- testbench/tb_chrono_cube.sv
// Uses a 24x10 frame; the VRAM model answers within the cycle and starts from a fill pattern
`timescale 1ns/1ps
`default_nettype none

module tb_chrono_cube import chrono_pkg::*; ();

  logic                       clk;
  logic                       rst_n;
  mpu_req_t                   mpu_req;
  word_t                      rdata;
  logic                       rdata_valid;
  logic                       vram_en;
  logic                       vram_rd;
  logic                       vram_wr;
  logic [1:0]                 vram_be;
  logic [VRAM_ADDR_WIDTH-1:0] vram_addr;
  word_t                      vram_wdata;
  word_t                      vram_rdata;
  logic                       vga_hsync;
  logic                       vga_vsync;

  word_t       vram_mem [65536];
  logic [7:0]  pal_red [256];
  logic [7:0]  pal_green [256];
  logic [7:0]  pal_blue [256];
  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  logic        timed_out;

  chrono_cube #(
    .H_VISIBLE (16),
    .H_FRONT   (2),
    .H_SYNC    (3),
    .H_BACK    (3),
    .V_VISIBLE (6),
    .V_FRONT   (1),
    .V_SYNC    (2),
    .V_BACK    (1)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .mpu_req     (mpu_req),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .vram_en     (vram_en),
    .vram_rd     (vram_rd),
    .vram_wr     (vram_wr),
    .vram_be     (vram_be),
    .vram_addr   (vram_addr),
    .vram_wdata  (vram_wdata),
    .vram_rdata  (vram_rdata),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync)
  );

  always #50 clk = ~clk;

  // VRAM model with combinational read and per-lane write
  assign vram_rdata = (vram_rd === 1'b1) ? vram_mem[vram_addr] : 16'h0000;

  always @(posedge clk) begin
    if (vram_wr === 1'b1) begin
      if (vram_be[0]) vram_mem[vram_addr][7:0] <= vram_wdata[7:0];
      if (vram_be[1]) vram_mem[vram_addr][15:8] <= vram_wdata[15:8];
    end
  end

  function automatic word_t fill_word(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ 16'h3c96;
  endfunction

  function automatic word_t merge_lanes(input word_t old, input word_t upd, input logic [1:0] be);
    return {be[1] ? upd[15:8] : old[15:8], be[0] ? upd[7:0] : old[7:0]};
  endfunction

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%-12s %s, %0d errors", name, (errors == err0) ? "ok" : "mismatch", errors - err0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [1:0] be, input word_t data);
    mpu_req = '{rd: 1'b0, wr: 1'b1, be: be, addr: addr, wdata: data};
    @(posedge clk);
    #1;
    mpu_req = '0;
  endtask

  // Response is due exactly one cycle after the strobe
  task automatic read_word(input logic [15:0] addr, output word_t data);
    mpu_req = '{rd: 1'b1, wr: 1'b0, be: 2'b11, addr: addr, wdata: 16'h0000};
    @(posedge clk);
    #1;
    mpu_req = '0;
    check_word(rdata_valid, 1'b1, "rdata_valid one cycle after read");
    data = rdata;
  endtask

  task automatic read_check(input logic [15:0] addr, input word_t exp, input string what);
    word_t d;
    read_word(addr, d);
    check_word(d, exp, what);
  endtask

  task automatic wait_level(input int which, input logic level, input int limit, output int n);
    logic s;
    n = 0;
    s = (which == 0) ? vga_hsync : vga_vsync;
    while (s !== level && n < limit) begin
      @(posedge clk);
      #1;
      n++;
      s = (which == 0) ? vga_hsync : vga_vsync;
    end
    if (s !== level) begin
      $display("Timeout: %s did not reach level %0d within %0d cycles",
               (which == 0) ? "vga_hsync" : "vga_vsync", level, limit);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic test_reset_id();
    int err0;
    err0 = errors;
    check_word(vram_en, 1'b0, "vram_en after reset");
    check_word(vram_rd, 1'b0, "vram_rd after reset");
    check_word(vram_wr, 1'b0, "vram_wr after reset");
    check_word(rdata_valid, 1'b0, "rdata_valid after reset");
    check_word(vga_hsync, 1'b1, "vga_hsync after reset");
    check_word(vga_vsync, 1'b1, "vga_vsync after reset");
    read_check(16'h0000, ID_VALUE, "ID register");
    read_check(16'h0001, 16'h0000, "SYS_CTRL after reset");
    read_check(16'h0002, 16'h0000, "MEM_BANK after reset");
    for (int i = 6; i < 16; i++) begin
      read_check(16'(i), 16'h0000, "unused register index");
    end
    report_test("reset_id", err0);
  endtask

  task automatic test_registers();
    int         err0;
    word_t      d;
    word_t      exp;
    logic [1:0] be;
    err0 = errors;
    exp  = '0;
    for (int k = 0; k < 6; k++) begin
      d  = rand_bits(16);
      be = 2'(rand_bits(2));
      write_word(16'h0001, be, d);
      exp = merge_lanes(exp, d, be);
      read_check(16'h0001, exp, "SYS_CTRL lane merge");
    end
    write_word(16'h0001, 2'b11, 16'h0000);
    exp = '0;
    for (int k = 0; k < 4; k++) begin
      d  = rand_bits(16);
      be = 2'(rand_bits(2));
      write_word(16'h0002, be, d);
      if (be[0]) exp = {8'h00, d[7:0]};
      read_check(16'h0002, exp, "MEM_BANK low byte only");
    end
    write_word(16'h0002, 2'b11, 16'h0000);
    write_word(16'h0000, 2'b11, 16'hffff);
    read_check(16'h0000, ID_VALUE, "ID after write");
    // Scan position never exceeds the visible width
    write_word(16'h0004, 2'b11, 16'h03ff);
    read_word(16'h0004, d);
    check_word(d < 16, 1'b1, "SCAN_X write ignored");
    report_test("registers", err0);
  endtask

  task automatic test_palette();
    int          err0;
    logic [7:0]  idx [8];
    logic [15:0] base;
    logic [15:0] addr [16];
    word_t       exp [16];
    word_t       d;
    logic [1:0]  be;
    err0 = errors;
    for (int k = 0; k < 8; k++) begin
      idx[k] = 8'(rand_bits(8));
      base   = 16'h0800 | {7'b0, idx[k], 1'b0};
      d = rand_bits(16);
      write_word(base, 2'b11, d);
      pal_red[idx[k]]   = d[7:0];
      pal_green[idx[k]] = d[15:8];
      d = rand_bits(16);
      write_word(base | 16'h1, 2'b11, d);
      pal_blue[idx[k]] = d[7:0];
      d  = rand_bits(16);
      be = 2'(rand_bits(2));
      write_word(base, be, d);
      if (be[0]) pal_red[idx[k]] = d[7:0];
      if (be[1]) pal_green[idx[k]] = d[15:8];
      d  = rand_bits(16);
      be = 2'(rand_bits(2));
      write_word(base | 16'h1, be, d);
      if (be[0]) pal_blue[idx[k]] = d[7:0];
    end
    for (int k = 0; k < 8; k++) begin
      addr[2*k]     = 16'h0800 | {7'b0, idx[k], 1'b0};
      addr[2*k + 1] = addr[2*k] | 16'h1;
      exp[2*k]      = {pal_green[idx[k]], pal_red[idx[k]]};
      exp[2*k + 1]  = {8'h00, pal_blue[idx[k]]};
    end
    // Back-to-back reads return one response per cycle
    for (int k = 0; k <= 16; k++) begin
      if (k > 0) begin
        check_word(rdata_valid, 1'b1, "rdata_valid in palette burst");
        check_word(rdata, exp[k-1], "palette burst read");
      end
      if (k < 16) begin
        mpu_req = '{rd: 1'b1, wr: 1'b0, be: 2'b11, addr: addr[k], wdata: 16'h0000};
        @(posedge clk);
        #1;
      end else begin
        mpu_req = '0;
      end
    end
    report_test("palette", err0);
  endtask

  task automatic test_vram();
    int          err0;
    logic [11:0] off_a;
    logic [11:0] off_b;
    logic [11:0] off_c;
    word_t       d_a;
    word_t       d_b;
    word_t       d_c;
    word_t       exp_b;
    err0  = errors;
    off_a = 12'(rand_bits(12));
    off_b = off_a ^ 12'h800;
    off_c = 12'(rand_bits(12));
    write_word(16'h0002, 2'b11, 16'h0010);
    read_check({4'h1, off_a}, UNMAPPED_VALUE, "VRAM read with access off");
    check_word(vram_en, 1'b0, "vram_en with access off");
    check_word(vram_rd, 1'b0, "vram_rd with access off");
    write_word({4'h1, off_a}, 2'b11, 16'hffff);
    check_word(vram_wr, 1'b0, "vram_wr with access off");
    write_word(16'h0001, 2'b01, 16'h0001);
    check_word(vram_en, 1'b1, "vram_en with access on");
    d_a = rand_bits(16);
    write_word({4'h1, off_a}, 2'b11, d_a);
    d_b = rand_bits(16);
    write_word({4'h1, off_b}, 2'b10, d_b);
    exp_b = merge_lanes(fill_word({4'h0, off_b}), d_b, 2'b10);
    idle_cycles(1);
    check_word(vram_mem[{4'h0, off_a}], d_a, "VRAM model full write");
    check_word(vram_mem[{4'h0, off_b}], exp_b, "VRAM model high lane write");
    read_check({4'h1, off_a}, d_a, "VRAM read back full write");
    read_check({4'h1, off_b}, exp_b, "VRAM read back lane write");
    read_check({4'h1, off_a ^ 12'h400}, fill_word({4'h0, off_a ^ 12'h400}), "VRAM fill word");
    // Next bank reaches the second 4K of VRAM
    write_word(16'h0002, 2'b11, 16'h0011);
    d_c = rand_bits(16);
    write_word({4'h1, off_c}, 2'b11, d_c);
    idle_cycles(1);
    check_word(vram_mem[{4'h1, off_c}], d_c, "VRAM model write via bank 0x11");
    read_check({4'h1, off_c}, d_c, "VRAM read via bank 0x11");
    read_check(16'h0002, 16'h0011, "MEM_BANK through page 0");
    read_check(16'h0000, ID_VALUE, "ID through page 0");
    write_word(16'h0001, 2'b11, 16'h0000);
    check_word(vram_en, 1'b0, "vram_en after access off");
    report_test("vram", err0);
  endtask

  task automatic test_unmapped();
    int err0;
    err0 = errors;
    write_word(16'h0002, 2'b11, 16'h0000);
    read_check(16'h0a00, UNMAPPED_VALUE, "palette base plus 512");
    read_check(16'h0010, UNMAPPED_VALUE, "past the register block");
    write_word(16'h0002, 2'b11, 16'h0005);
    read_check(16'h1000, UNMAPPED_VALUE, "bank 0x05 low word");
    read_check(16'h1ffe, UNMAPPED_VALUE, "bank 0x05 high word");
    write_word(16'h0002, 2'b11, 16'h0000);
    report_test("unmapped", err0);
  endtask

  task automatic test_timing();
    int    err0;
    int    n;
    int    n_low;
    int    n_high;
    word_t d;
    err0 = errors;
    wait_level(0, 1'b1, 30, n);
    wait_level(0, 1'b0, 30, n);
    wait_level(0, 1'b1, 30, n_low);
    wait_level(0, 1'b0, 30, n_high);
    check_word(16'(n_low), 16'd3, "hsync low cycles");
    check_word(16'(n_low + n_high), 16'd24, "hsync period");
    wait_level(1, 1'b1, 300, n);
    wait_level(1, 1'b0, 300, n);
    wait_level(1, 1'b1, 300, n_low);
    wait_level(1, 1'b0, 300, n_high);
    check_word(16'(n_low), 16'd48, "vsync low cycles");
    check_word(16'(n_low + n_high), 16'd240, "vsync period");
    read_word(16'h0003, d);
    check_word(d[1], 1'b0, "OUTPUT_STATUS v_sync during vsync");
    check_word(d[3], 1'b1, "OUTPUT_STATUS v_blank during vsync");
    check_word(d[15:4], 12'h000, "OUTPUT_STATUS upper bits");
    report_test("timing", err0);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    mpu_req    = '0;
    lfsr_state = 32'hc020_2c91;
    checks     = 0;
    errors     = 0;
    timed_out  = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      vram_mem[i] = fill_word(16'(i));
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_id();
    test_registers();
    test_palette();
    test_vram();
    test_unmapped();
    test_timing();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- chrono_cube.f
hdl/chrono_pkg.sv
hdl/mpu_decoder.sv
hdl/main_registers.sv
hdl/palette_ram.sv
hdl/display_timing.sv
hdl/vram_port.sv
hdl/chrono_cube.sv
testbench/tb_chrono_cube.sv

//--- Bender.yml
package:
  name: chrono_cube

sources:
  - files:
      - hdl/chrono_pkg.sv
      - hdl/mpu_decoder.sv
      - hdl/main_registers.sv
      - hdl/palette_ram.sv
      - hdl/display_timing.sv
      - hdl/vram_port.sv
      - hdl/chrono_cube.sv
  - target: test
    files:
      - testbench/tb_chrono_cube.sv
